// ==== corr_config.svh ====
`ifndef CORR_CONFIG_SVH
`define CORR_CONFIG_SVH

// --------------------
// array geometry
// --------------------

// antennas feeding every block, one bit per antenna per component
`define CORR_ANT 8

// pairs visited by one multiply-accumulate unit per frame
`define CORR_PAIRS_PER_BLK 14

// peer correlator blocks, 28 pairs over the whole array
`define CORR_NBLK 2

// --------------------
// accumulation
// --------------------

`define CORR_ACCUM 16      // bits per real or imaginary sum, wraps on overflow

`define CORR_INT_LEN 16    // frames per integration before a dump

`endif

// ==== corr_pkg.sv ====
`default_nettype none

`include "corr_config.svh"

package corr_pkg;

   localparam int NPAIRS = `CORR_PAIRS_PER_BLK * `CORR_NBLK;   // 28 pairs in all

   typedef logic [$clog2(`CORR_ANT)-1:0] ant_idx_t;
   typedef logic [$clog2(NPAIRS)-1:0]    pair_idx_t;        // global pair, 5 bits

   // one sample per antenna, bit set means +1, clear means -1
   typedef struct packed {
      logic [`CORR_ANT-1:0] re;
      logic [`CORR_ANT-1:0] im;
   } frame_t;

   typedef logic signed [`CORR_ACCUM-1:0] acc_t;

   typedef struct packed {
      acc_t re;   // real sum
      acc_t im;   // imaginary sum
   } vis_t;

   // record handed from a block through the arbiter into the memory
   typedef struct packed {
      pair_idx_t pair;
      vis_t      vis;
   } vis_wr_t;

   typedef struct packed {
      ant_idx_t a;
      ant_idx_t b;   // always a < b
   } pair_t;

   // every a<b in lexicographic order, block g/14 owns slot g%14
   localparam pair_t pair_table [NPAIRS] = '{
      '{3'd0, 3'd1}, '{3'd0, 3'd2}, '{3'd0, 3'd3}, '{3'd0, 3'd4}, '{3'd0, 3'd5},
      '{3'd0, 3'd6}, '{3'd0, 3'd7}, '{3'd1, 3'd2}, '{3'd1, 3'd3}, '{3'd1, 3'd4},
      '{3'd1, 3'd5}, '{3'd1, 3'd6}, '{3'd1, 3'd7}, '{3'd2, 3'd3}, '{3'd2, 3'd4},
      '{3'd2, 3'd5}, '{3'd2, 3'd6}, '{3'd2, 3'd7}, '{3'd3, 3'd4}, '{3'd3, 3'd5},
      '{3'd3, 3'd6}, '{3'd3, 3'd7}, '{3'd4, 3'd5}, '{3'd4, 3'd6}, '{3'd4, 3'd7},
      '{3'd5, 3'd6}, '{3'd5, 3'd7}, '{3'd6, 3'd7}
   };

endpackage

`default_nettype wire

// ==== apb_pkg.sv ====
`default_nettype none

`include "corr_config.svh"

package apb_pkg;

   typedef logic [7:0]  apb_addr_t;   // byte address
   typedef logic [31:0] apb_data_t;

   // --------------------
   // register map
   // --------------------
   // word 2g is the real part of pair g, word 2g+1 the imaginary part
   localparam int VIS_WORDS = 2 * `CORR_PAIRS_PER_BLK * `CORR_NBLK;   // 56

   localparam apb_addr_t STATUS_ADDR = 8'hE0;              // completed integrations
   localparam apb_addr_t ADDR_END    = STATUS_ADDR + 8'd4; // first unmapped byte

   typedef logic [5:0] word_idx_t;   // paddr[7:2]

   typedef enum logic {
      WORD_RE = 1'b0,
      WORD_IM = 1'b1
   } word_sel_e;

endpackage

`default_nettype wire

// ==== correlator_block.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "corr_config.svh"

module correlator_block import corr_pkg::*; #(
   parameter int BLK_ID = 0      // picks this block's slice of pair_table
) (
   input  wire logic    clk_x,
   input  wire logic    rst,
   input  wire logic    frame_vld_i,   // already qualified by frame_rdy
   input  wire frame_t  frame_i,
   output logic         idle_o,
   output logic         wr_req_o,
   input  wire logic    wr_gnt_i,
   output vis_wr_t      wr_rec_o
);

   localparam int NSLOT = `CORR_PAIRS_PER_BLK;
   localparam int BASE  = BLK_ID * NSLOT;          // first global pair
   localparam int FCW   = $clog2(`CORR_INT_LEN);

   typedef logic [$clog2(NSLOT)-1:0] slot_t;

   localparam slot_t          LAST_SLOT = slot_t'(NSLOT - 1);
   localparam logic [FCW-1:0] LAST_FRM  = FCW'(`CORR_INT_LEN - 1);

   typedef enum logic [2:0] {
      S_IDLE,
      S_RUN,        // one slot issued per cycle
      S_DRAIN,      // let the last writes land
      S_DUMP_RD,    // read and zero one entry
      S_DUMP_REQ    // hold the record until granted
   } state_e;

   state_e         state_q;
   slot_t          slot_q;            // shared by MAC sweep and dump
   slot_t          slot1_q, slot2_q;  // slot in add and write-back stage
   logic [FCW-1:0] frm_cnt_q;
   logic           v1_q, v2_q;        // add and write-back stage valid
   logic [NSLOT-1:0] live_q;          // entry written since reset

   frame_t frame_q;
   vis_t   scratch [NSLOT];
   vis_t   rd_q;
   logic   rd_live_q;
   vis_t   sum_q;
   vis_t   acc;
   pair_t  pr;
   acc_t   re_inc, im_inc;

   // one-bit sample to +1 / -1
   function automatic acc_t pm1(input logic b);
      return b ? acc_t'(1) : acc_t'(-1);
   endfunction

   // --------------------
   // add stage
   // --------------------
   // x_a * conj(x_b), products of +-1 are an xnor of the sign bits
   always_comb begin
      pr     = pair_table[BASE + int'(slot1_q)];
      acc    = rd_live_q ? rd_q : '0;   // untouched entries count as zero
      re_inc = pm1(frame_q.re[pr.a] ~^ frame_q.re[pr.b])
             + pm1(frame_q.im[pr.a] ~^ frame_q.im[pr.b]);
      im_inc = pm1(frame_q.im[pr.a] ~^ frame_q.re[pr.b])
             - pm1(frame_q.re[pr.a] ~^ frame_q.im[pr.b]);
   end

   // --------------------
   // sequencer
   // --------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         state_q   <= S_IDLE;
         slot_q    <= '0;
         frm_cnt_q <= '0;
         v1_q      <= 1'b0;
         v2_q      <= 1'b0;
         live_q    <= '0;
      end else begin
         v1_q <= (state_q == S_RUN);   // a read issues every run cycle
         v2_q <= v1_q;
         if (v2_q)
            live_q[slot2_q] <= 1'b1;
         case (state_q)
            S_IDLE: if (frame_vld_i) begin
               state_q <= S_RUN;
               slot_q  <= '0;
            end
            S_RUN: if (slot_q == LAST_SLOT) begin
               slot_q <= '0;
               if (frm_cnt_q == LAST_FRM) begin   // integration complete
                  frm_cnt_q <= '0;
                  state_q   <= S_DRAIN;
               end else begin
                  frm_cnt_q <= frm_cnt_q + 1'b1;
                  state_q   <= S_IDLE;
               end
            end else begin
               slot_q <= slot_q + 1'b1;
            end
            S_DRAIN: if (!v1_q && !v2_q)
               state_q <= S_DUMP_RD;
            S_DUMP_RD:
               state_q <= S_DUMP_REQ;
            S_DUMP_REQ: if (wr_gnt_i) begin
               if (slot_q == LAST_SLOT) begin
                  slot_q  <= '0;
                  state_q <= S_IDLE;
               end else begin
                  slot_q  <= slot_q + 1'b1;
                  state_q <= S_DUMP_RD;
               end
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   // --------------------
   // scratch pipeline
   // --------------------
   always_ff @(posedge clk_x) begin
      if (state_q == S_IDLE && frame_vld_i)
         frame_q <= frame_i;
      if (state_q != S_DUMP_REQ) begin   // record stays put while waiting
         rd_q      <= scratch[slot_q];
         rd_live_q <= live_q[slot_q];
      end
      slot1_q  <= slot_q;
      slot2_q  <= slot1_q;
      sum_q.re <= acc.re + re_inc;   // wraps
      sum_q.im <= acc.im + im_inc;
      if (v2_q)
         scratch[slot2_q] <= sum_q;
      else if (state_q == S_DUMP_RD)
         scratch[slot_q] <= '0;       // cleared for the next integration
   end

   assign idle_o   = (state_q == S_IDLE);
   assign wr_req_o = (state_q == S_DUMP_REQ);

   always_comb begin
      wr_rec_o.pair = pair_idx_t'(BASE + int'(slot_q));
      wr_rec_o.vis  = acc;
   end

endmodule

`default_nettype wire

// ==== vis_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module vis_arbiter #(
   parameter int  N         = 2,       // requesters
   parameter type payload_t = logic
) (
   input  wire logic         clk_x,
   input  wire logic         rst,
   input  wire logic [N-1:0] req_i,
   input  wire payload_t     pay_i [N],
   output logic [N-1:0]      gnt_o,    // one-hot or zero
   output logic              we_o,
   output payload_t          pay_o
);

   localparam int PW = (N > 1) ? $clog2(N) : 1;

   logic [PW-1:0] ptr_q;   // highest priority this cycle
   logic [PW-1:0] win;
   logic          any;

   // --------------------
   // rotating search
   // --------------------
   always_comb begin
      int unsigned idx;
      gnt_o = '0;
      win   = ptr_q;
      any   = 1'b0;
      for (int k = 0; k < N; k++) begin
         idx = (int'(ptr_q) + k) % N;   // walk from the pointer, wrapping
         if (!any && req_i[idx]) begin
            any        = 1'b1;
            win        = idx[PW-1:0];
            gnt_o[idx] = 1'b1;
         end
      end
   end

   always_ff @(posedge clk_x) begin
      if (rst) begin
         ptr_q <= '0;
         we_o  <= 1'b0;
      end else begin
         we_o <= any;   // strobe lines up with the registered record
         if (any)
            ptr_q <= (int'(win) == N - 1) ? '0 : win + 1'b1;   // next after winner
      end
   end

   always_ff @(posedge clk_x) begin
      if (any)
         pay_o <= pay_i[win];
   end

endmodule

`default_nettype wire

// ==== vis_bank_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module vis_bank_ram import corr_pkg::*, apb_pkg::*; (
   input  wire logic      clk_x,
   input  wire logic      rst,
   input  wire logic      we_i,
   input  wire vis_wr_t   rec_i,
   input  wire word_idx_t rd_word_i,     // combinational from paddr
   output apb_data_t      rd_data_o,
   output logic [15:0]    int_count_o
);

   localparam int EXT = $bits(apb_data_t) - $bits(acc_t);   // sign-extension bits

   vis_t      bank_mem [2][NPAIRS];   // [bank][pair]
   logic      fill_q;                 // bank taking writes
   pair_idx_t wr_cnt_q;
   pair_idx_t rd_pair;
   word_sel_e rd_sel;
   vis_t      rd_vis;
   acc_t      rd_half;

   // --------------------
   // fill side
   // --------------------
   always_ff @(posedge clk_x) begin
      if (we_i)
         bank_mem[fill_q][rec_i.pair] <= rec_i.vis;
   end

   // 28th write closes the set, flip and count
   always_ff @(posedge clk_x) begin
      if (rst) begin
         fill_q      <= 1'b0;
         wr_cnt_q    <= '0;
         int_count_o <= '0;
      end else if (we_i) begin
         if (wr_cnt_q == pair_idx_t'(NPAIRS - 1)) begin
            wr_cnt_q    <= '0;
            fill_q      <= ~fill_q;
            int_count_o <= int_count_o + 16'd1;
         end else begin
            wr_cnt_q <= wr_cnt_q + 1'b1;
         end
      end
   end

   // --------------------
   // read side
   // --------------------
   assign rd_pair = pair_idx_t'(rd_word_i >> 1);
   assign rd_sel  = word_sel_e'(rd_word_i[0]);

   always_comb begin
      rd_vis  = (rd_pair < NPAIRS) ? bank_mem[~fill_q][rd_pair] : '0;   // completed bank
      rd_half = (rd_sel == WORD_IM) ? rd_vis.im : rd_vis.re;
   end

   always_ff @(posedge clk_x) begin
      rd_data_o <= {{EXT{rd_half[$bits(acc_t)-1]}}, rd_half};
   end

endmodule

`default_nettype wire

// ==== apb_vis_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module apb_vis_port import apb_pkg::*; (
   input  wire logic        clk_x,
   input  wire logic        rst,
   input  wire logic        psel_i,
   input  wire logic        penable_i,
   input  wire logic        pwrite_i,
   input  wire apb_addr_t   paddr_i,
   input  wire apb_data_t   pwdata_i,     // visibilities are read only
   output apb_data_t        prdata_o,
   output logic             pready_o,
   output logic             pslverr_o,
   output word_idx_t        rd_word_o,
   input  wire apb_data_t   rd_data_i,    // one cycle behind rd_word_o
   input  wire logic [15:0] int_count_i
);

   typedef enum logic {
      ST_IDLE,   // setup or first access cycle
      ST_ACK     // second access cycle, pready high
   } st_e;

   st_e         st_q;
   logic        err_q;      // decoded at the first access cycle
   logic        is_stat_q;
   logic [15:0] stat_q;     // count sampled for this access
   logic        acc_start;

   assign rd_word_o = word_idx_t'(paddr_i[7:2]);
   assign acc_start = psel_i && penable_i && (st_q == ST_IDLE);

   // --------------------
   // wait-state FSM
   // --------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         st_q      <= ST_IDLE;
         err_q     <= 1'b0;
         is_stat_q <= 1'b0;
      end else begin
         case (st_q)
            ST_IDLE: if (acc_start)
               st_q <= ST_ACK;
            ST_ACK:
               st_q <= ST_IDLE;   // one wait state, then done
            default: st_q <= ST_IDLE;
         endcase
         if (acc_start) begin
            err_q     <= pwrite_i || (paddr_i >= ADDR_END);
            is_stat_q <= (paddr_i[7:2] == STATUS_ADDR[7:2]);
         end
      end
   end

   always_ff @(posedge clk_x) begin
      if (acc_start)
         stat_q <= int_count_i;
   end

   // --------------------
   // response
   // --------------------
   assign pready_o  = (st_q == ST_ACK);
   assign pslverr_o = (st_q == ST_ACK) && err_q;

   always_comb begin
      prdata_o = '0;
      if (st_q == ST_ACK && !err_q) begin
         if (is_stat_q)
            prdata_o = apb_data_t'(stat_q);    // zero-extended count
         else if (int'(rd_word_o) < VIS_WORDS)
            prdata_o = rd_data_i;
      end
   end

endmodule

`default_nettype wire

// ==== corr_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "corr_config.svh"

module corr_top import corr_pkg::*, apb_pkg::*; (
   input  wire logic                 clk_x,
   input  wire logic                 rst,
   // sample input
   input  wire logic                 frame_vld_i,
   input  wire logic [`CORR_ANT-1:0] frame_re_i,
   input  wire logic [`CORR_ANT-1:0] frame_im_i,
   output logic                      frame_rdy_o,
   // APB slave
   input  wire logic                 psel_i,
   input  wire logic                 penable_i,
   input  wire logic                 pwrite_i,
   input  wire apb_addr_t            paddr_i,
   input  wire apb_data_t            pwdata_i,
   output apb_data_t                 prdata_o,
   output logic                      pready_o,
   output logic                      pslverr_o
);

   localparam int NBLK = `CORR_NBLK;

   frame_t          frame;
   logic            frame_take;   // frame handshake
   logic            rdy_en_q;     // high from the cycle after reset
   logic [NBLK-1:0] blk_idle;
   logic [NBLK-1:0] blk_req;
   logic [NBLK-1:0] blk_gnt;
   vis_wr_t         blk_rec [NBLK];
   logic            mem_we;
   vis_wr_t         mem_rec;
   word_idx_t       rd_word;
   apb_data_t       rd_data;
   logic [15:0]     int_count;

   assign frame.re = frame_re_i;
   assign frame.im = frame_im_i;

   // --------------------
   // frame handshake
   // --------------------
   always_ff @(posedge clk_x) begin
      if (rst)
         rdy_en_q <= 1'b0;
      else
         rdy_en_q <= 1'b1;
   end

   // every block shares the frame, so all must be idle, a dump holds it low
   assign frame_rdy_o = rdy_en_q && (&blk_idle);
   assign frame_take  = frame_vld_i && frame_rdy_o;

   // --------------------
   // correlator blocks
   // --------------------
   for (genvar b = 0; b < NBLK; b++) begin : g_blk
      correlator_block #(
         .BLK_ID (b)
      ) u_blk (
         .clk_x       (clk_x),
         .rst         (rst),
         .frame_vld_i (frame_take),
         .frame_i     (frame),
         .idle_o      (blk_idle[b]),
         .wr_req_o    (blk_req[b]),
         .wr_gnt_i    (blk_gnt[b]),
         .wr_rec_o    (blk_rec[b])
      );
   end

   vis_arbiter #(
      .N         (NBLK),
      .payload_t (vis_wr_t)
   ) u_arb (
      .clk_x (clk_x),
      .rst   (rst),
      .req_i (blk_req),
      .pay_i (blk_rec),
      .gnt_o (blk_gnt),
      .we_o  (mem_we),
      .pay_o (mem_rec)
   );

   // --------------------
   // visibility store and bus
   // --------------------
   vis_bank_ram u_ram (
      .clk_x       (clk_x),
      .rst         (rst),
      .we_i        (mem_we),
      .rec_i       (mem_rec),
      .rd_word_i   (rd_word),
      .rd_data_o   (rd_data),
      .int_count_o (int_count)
   );

   apb_vis_port u_apb (
      .clk_x       (clk_x),
      .rst         (rst),
      .psel_i      (psel_i),
      .penable_i   (penable_i),
      .pwrite_i    (pwrite_i),
      .paddr_i     (paddr_i),
      .pwdata_i    (pwdata_i),
      .prdata_o    (prdata_o),
      .pready_o    (pready_o),
      .pslverr_o   (pslverr_o),
      .rd_word_o   (rd_word),
      .rd_data_i   (rd_data),
      .int_count_i (int_count)
   );

endmodule

`default_nettype wire

// ==== corr_top_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "corr_config.svh"

module corr_top_chk (
   input wire logic                   clk_x,
   input wire logic                   rst,
   input wire logic [`CORR_NBLK-1:0]  req_i,    // block write requests
   input wire logic [`CORR_NBLK-1:0]  gnt_i,
   input wire logic                   frame_vld_i,
   input wire logic                   frame_rdy_i,
   input wire logic                   psel_i,
   input wire logic                   penable_i,
   input wire logic                   pready_i
);

   localparam int NPAIRS = `CORR_PAIRS_PER_BLK * `CORR_NBLK;   // one grant per pair

   int   assert_fails = 0;   // read by the testbench at the end
   int   frm_seen;           // frames taken in the open integration
   int   gnt_seen;           // grants of the running dump
   logic dump_pend;          // integration closed, pairs still to be written

   // --------------------
   // dump tracking
   // --------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         frm_seen  <= 0;
         gnt_seen  <= 0;
         dump_pend <= 1'b0;
      end else begin
         if (frame_vld_i && frame_rdy_i) begin
            if (frm_seen == `CORR_INT_LEN - 1) begin
               frm_seen  <= 0;
               dump_pend <= 1'b1;   // the dump follows this frame
            end else begin
               frm_seen <= frm_seen + 1;
            end
         end
         if (gnt_i != '0) begin
            if (gnt_seen == NPAIRS - 1) begin
               gnt_seen  <= 0;
               dump_pend <= 1'b0;   // every block has handed over its last entry
            end else begin
               gnt_seen <= gnt_seen + 1;
            end
         end
      end
   end

   // --------------------
   // arbiter
   // --------------------
   a_gnt_onehot: assert property (@(posedge clk_x) disable iff (rst) $onehot0(gnt_i))
      else begin
         $error("arbiter grant is not one-hot or zero");
         assert_fails++;
      end

   a_gnt_req: assert property (@(posedge clk_x) disable iff (rst) (gnt_i & ~req_i) == '0)
      else begin
         $error("grant given to a block that is not requesting");
         assert_fails++;
      end

   // --------------------
   // APB and frame input
   // --------------------
   // exactly one wait state
   a_pready: assert property (@(posedge clk_x) disable iff (rst)
                              (psel_i && $rose(penable_i)) |-> !pready_i ##1 pready_i)
      else begin
         $error("pready did not rise one cycle after penable");
         assert_fails++;
      end

   a_frame_bp: assert property (@(posedge clk_x) disable iff (rst)
                                (frame_vld_i && frame_rdy_i) |-> !dump_pend)
      else begin
         $error("frame accepted while a block was dumping");
         assert_fails++;
      end

endmodule

`default_nettype wire

// ==== tb_corr_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "corr_config.svh"

module tb_corr_top;

   localparam int         NPAIR     = 28;
   localparam int         NWORD     = 56;
   localparam int         NINT      = 2;       // integrations run
   localparam logic [7:0] STAT_ADDR = 8'hE0;

   logic        clk_x;
   logic        rst;
   logic        frame_vld_i;
   logic [7:0]  frame_re_i;
   logic [7:0]  frame_im_i;
   logic        frame_rdy_o;
   logic        psel_i;
   logic        penable_i;
   logic        pwrite_i;
   logic [7:0]  paddr_i;
   logic [31:0] pwdata_i;
   logic [31:0] prdata_o;
   logic        pready_o;
   logic        pslverr_o;

   integer seed = 83290;
   int     check_errs;
   int     timeout_errs;
   int     frames_taken;         // handshakes seen so far
   int     frame_target;         // driver offers frames until this count
   int     ints_done;
   int     pa [NPAIR];           // antenna a of global pair g
   int     pb [NPAIR];

   logic signed [15:0] sum_re [NPAIR];          // running sums, wrap like the DUT
   logic signed [15:0] sum_im [NPAIR];
   logic signed [15:0] exp_re [NINT][NPAIR];    // one copy per completed integration
   logic signed [15:0] exp_im [NINT][NPAIR];

   corr_top u_corr_top (
      .clk_x       (clk_x),
      .rst         (rst),
      .frame_vld_i (frame_vld_i),
      .frame_re_i  (frame_re_i),
      .frame_im_i  (frame_im_i),
      .frame_rdy_o (frame_rdy_o),
      .psel_i      (psel_i),
      .penable_i   (penable_i),
      .pwrite_i    (pwrite_i),
      .paddr_i     (paddr_i),
      .pwdata_i    (pwdata_i),
      .prdata_o    (prdata_o),
      .pready_o    (pready_o),
      .pslverr_o   (pslverr_o)
   );

   bind corr_top corr_top_chk u_chk (
      .clk_x       (clk_x),
      .rst         (rst),
      .req_i       (blk_req),
      .gnt_i       (blk_gnt),
      .frame_vld_i (frame_vld_i),
      .frame_rdy_i (frame_rdy_o),
      .psel_i      (psel_i),
      .penable_i   (penable_i),
      .pready_i    (pready_o)
   );

   initial begin
      clk_x = 1'b0;
      forever #50 clk_x = ~clk_x;   // 100 ns period
   end

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
      if (got !== want) begin
         $display("error %s: got 0x%08h expected 0x%08h", name, got, want);
         check_errs++;
      end
   endtask

   // --------------------
   // correlation model
   // --------------------
   // x_a * conj(x_b) with samples of +1 / -1
   task automatic model_add(input logic [7:0] re, input logic [7:0] im);
      int ra, ia, rb, ib;
      for (int g = 0; g < NPAIR; g++) begin
         ra = re[pa[g]] ? 1 : -1;
         ia = im[pa[g]] ? 1 : -1;
         rb = re[pb[g]] ? 1 : -1;
         ib = im[pb[g]] ? 1 : -1;
         sum_re[g] = 16'(sum_re[g] + ra * rb + ia * ib);
         sum_im[g] = 16'(sum_im[g] + ia * rb - ra * ib);
      end
      frames_taken++;
      if (frames_taken % `CORR_INT_LEN == 0) begin   // integration closed
         for (int g = 0; g < NPAIR; g++) begin
            if (ints_done < NINT) begin
               exp_re[ints_done][g] = sum_re[g];
               exp_im[ints_done][g] = sum_im[g];
            end
            sum_re[g] = '0;
            sum_im[g] = '0;
         end
         ints_done++;
      end
   endtask

   // frames with random gaps, held until accepted
   initial begin : frame_drive
      logic        took;
      logic [31:0] r;
      forever begin
         @(negedge clk_x);
         took = frame_vld_i && frame_rdy_o;   // handshake of the coming edge
         if (took)
            model_add(frame_re_i, frame_im_i);
         @(posedge clk_x);
         #1;
         if (!frame_vld_i || took) begin
            if (frames_taken < frame_target) begin
               r           = $random(seed);
               frame_vld_i = (r[17:16] != 2'b00);   // about one gap in four
               frame_re_i  = r[7:0];
               frame_im_i  = r[15:8];
            end else begin
               frame_vld_i = 1'b0;
            end
         end
      end
   end

   // --------------------
   // APB master
   // --------------------
   task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
      int n;
      psel_i    = 1'b1;   // setup phase
      penable_i = 1'b0;
      pwrite_i  = wr;
      paddr_i   = addr;
      pwdata_i  = wdata;
      @(posedge clk_x);
      #1;
      penable_i = 1'b1;
      n = 0;
      do begin
         @(posedge clk_x);
         #1;
         n++;
      end while (!pready_o && n < 8);
      if (!pready_o) begin
         $display("timeout: no pready_o on the access to 0x%02h", addr);
         timeout_errs++;
      end else begin
         check_val("pready_o wait cycles", 32'(n), 32'd1);
      end
      rdata = prdata_o;
      err   = pslverr_o;
      @(posedge clk_x);   // transfer completes on this edge
      #1;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
   endtask

   task automatic wait_frames(input int target);
      int n;
      n = 0;
      while (frames_taken < target && n < 4000) begin
         @(posedge clk_x);
         #1;
         n++;
      end
      if (frames_taken < target) begin
         $display("timeout: only %0d of %0d frames were accepted", frames_taken, target);
         timeout_errs++;
      end
   endtask

   task automatic wait_status(input int count);
      logic [31:0] d;
      logic        e;
      int          tries;
      tries = 0;
      d     = '0;
      while (d !== 32'(count) && tries < 100) begin   // poll STATUS
         apb_access(1'b0, STAT_ADDR, '0, d, e);
         tries++;
      end
      if (d !== 32'(count)) begin
         $display("timeout: STATUS never reached %0d integrations", count);
         timeout_errs++;
      end
   endtask

   // all 56 words, real at 8g and imaginary at 8g+4
   task automatic check_bank(input int idx);
      logic [31:0]        d;
      logic [31:0]        want;
      logic               e;
      logic signed [15:0] v;
      logic [7:0]         addr;
      for (int w = 0; w < NWORD; w++) begin
         v    = (w % 2 == 1) ? exp_im[idx][w / 2] : exp_re[idx][w / 2];
         want = {{16{v[15]}}, v};   // sign-extended
         addr = 8'(4 * w);
         apb_access(1'b0, addr, '0, d, e);
         check_val($sformatf("prdata_o @0x%02h", addr), d, want);
         check_val($sformatf("pslverr_o @0x%02h", addr), 32'(e), 32'd0);
      end
   endtask

   // --------------------
   // test sequence
   // --------------------
   initial begin : main_seq
      logic [31:0] d;
      logic        e;
      int          g;
      rst          = 1'b1;
      frame_vld_i  = 1'b0;
      frame_re_i   = '0;
      frame_im_i   = '0;
      psel_i       = 1'b0;
      penable_i    = 1'b0;
      pwrite_i     = 1'b0;
      paddr_i      = '0;
      pwdata_i     = '0;
      check_errs   = 0;
      timeout_errs = 0;
      frames_taken = 0;
      frame_target = 0;
      ints_done    = 0;
      g = 0;
      for (int a = 0; a < 8; a++) begin
         for (int b = a + 1; b < 8; b++) begin   // every a<b in lexicographic order
            pa[g] = a;
            pb[g] = b;
            g++;
         end
      end
      for (int k = 0; k < NPAIR; k++) begin
         sum_re[k] = '0;
         sum_im[k] = '0;
      end
      repeat (4) @(posedge clk_x);
      #1;
      check_val("frame_rdy_o in reset", 32'(frame_rdy_o), 32'd0);
      check_val("pready_o in reset", 32'(pready_o), 32'd0);
      check_val("pslverr_o in reset", 32'(pslverr_o), 32'd0);
      rst = 1'b0;

      apb_access(1'b0, STAT_ADDR, '0, d, e);
      check_val("STATUS after reset", d, 32'd0);

      frame_target = `CORR_INT_LEN;   // first integration
      wait_frames(frame_target);
      wait_status(1);
      check_bank(0);

      // bad accesses, data must survive
      apb_access(1'b1, 8'h08, $random(seed), d, e);
      check_val("pslverr_o on write", 32'(e), 32'd1);
      apb_access(1'b0, 8'hE4, '0, d, e);
      check_val("pslverr_o @0xe4", 32'(e), 32'd1);
      apb_access(1'b0, 8'hFC, '0, d, e);
      check_val("pslverr_o @0xfc", 32'(e), 32'd1);
      check_bank(0);

      // second integration from zeroed sums, one more frame is offered during its dump
      frame_target = 2 * `CORR_INT_LEN + 1;
      wait_frames(2 * `CORR_INT_LEN);
      wait_status(2);
      check_bank(1);
      wait_frames(frame_target);   // the held frame goes in once every block is idle

      repeat (4) @(posedge clk_x);
      $display("errors: %0d check, %0d timeout, %0d assertion",
               check_errs, timeout_errs, u_corr_top.u_chk.assert_fails);
      if (check_errs + timeout_errs + u_corr_top.u_chk.assert_fails == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
corr_pkg.sv
apb_pkg.sv
correlator_block.sv
vis_arbiter.sv
vis_bank_ram.sv
apb_vis_port.sv
corr_top.sv
corr_top_chk.sv
tb_corr_top.sv

// ==== Bender.yml ====
package:
  name: corr_top

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - corr_pkg.sv
      - apb_pkg.sv
      - correlator_block.sv
      - vis_arbiter.sv
      - vis_bank_ram.sv
      - apb_vis_port.sv
      - corr_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - corr_top_chk.sv
      - tb_corr_top.sv
